// File: Makefile
# Verilator flow for the dot-product unit

VERILATOR ?= verilator
TOP       ?= dotp_unit_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Fails unless the pass message shows up in the simulation output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/dotp_unit_tb.sv
`timescale 1ns/10ps

module dotp_unit_tb;
    import dotp_pkg::*;

    localparam real CLK_PERIOD = 4.0;
    localparam int RESET_CYCLES = 5;
    localparam int N_BP = RES_DEPTH + OUT_CREDITS + 4;
    localparam int N_RAND = 40;
    // Commands over all tests, sizes the watchdog
    localparam int NUM_CMDS = 5 + 5 + 5 + 8 + N_BP + N_RAND;
    localparam int DRAIN_LIMIT = 400;
    // Output credit return policies
    localparam int CRED_NOW = 0;
    localparam int CRED_HOLD = 1;
    localparam int CRED_RAND = 2;

    logic      clk_i;
    logic      reset;
    logic      req_valid;
    dotp_req_t req;
    logic      in_credit;
    logic      out_valid;
    dotp_res_t out_res;
    logic      out_credit;

    // Credit models and counters
    int in_cred;
    int owed;
    int cred_policy;
    int in_pulses;
    int received;
    int sent_total;
    int val_errs;
    int other_errs;

    // Reference model state
    logic             model_signed;
    logic [ACC_W-1:0] model_acc;
    dotp_res_t        exp_q[$];
    logic [TAG_W-1:0] next_tag;
    logic [31:0]      stim_lfsr;
    logic [31:0]      cred_lfsr;

    dotp_unit i_dotp_unit (
        .clk_i     (clk_i),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .in_credit (in_credit),
        .out_valid (out_valid),
        .out_res   (out_res),
        .out_credit(out_credit)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk_i = ~clk_i;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_step(inout logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        state = {state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step(stim_lfsr)};
        end
        return v;
    endfunction

    function automatic dotp_vec_t fill(input logic [ELEM_W-1:0] v);
        return {NUM_LANES{v}};
    endfunction

    // Expected result per dot, in command order
    function automatic void model_cmd(input dotp_req_t r);
        int        sum;
        int        pa;
        int        pb;
        dotp_res_t e;
        if (r.cmd.op == OP_CONFIG) begin
            model_signed = r.cmd.payload.cfg.is_signed;
            return;
        end
        sum = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (model_signed) begin
                pa = int'($signed(r.a[i]));
                pb = int'($signed(r.b[i]));
            end else begin
                pa = int'(r.a[i]);
                pb = int'(r.b[i]);
            end
            sum += pa * pb;
        end
        // Running sum wraps at the accumulator width
        if (r.cmd.payload.dot.chain) begin
            model_acc = model_acc + ACC_W'(sum);
        end else begin
            model_acc = ACC_W'(sum);
        end
        e.tag = r.cmd.payload.dot.tag;
        e.sum = model_acc;
        exp_q.push_back(e);
    endfunction

    task automatic check_res(input dotp_res_t got, input dotp_res_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t out_res got tag %0h sum %0d, expected tag %0h sum %0d",
                     $time, got.tag, got.sum, exp.tag, exp.sum);
            val_errs++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t %s got %0d, expected %0d", $time, name, got, exp);
            val_errs++;
        end
    endtask

    // All driving happens half a nanosecond after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #0.5;
        end
    endtask

    // Only sends while an input credit is held
    task automatic send(input dotp_req_t r);
        while (in_cred == 0) begin
            wait_cycles(1);
        end
        req_valid = 1'b1;
        req = r;
        in_cred--;
        sent_total++;
        model_cmd(r);
        wait_cycles(1);
        req_valid = 1'b0;
    endtask

    task automatic send_cfg(input logic is_signed);
        dotp_req_t r;
        r = '0;
        r.cmd.op = OP_CONFIG;
        r.cmd.payload.cfg.is_signed = is_signed;
        send(r);
    endtask

    task automatic send_dot(input logic chain, input dotp_vec_t a, input dotp_vec_t b);
        dotp_req_t r;
        r = '0;
        r.cmd.op = OP_DOT;
        r.cmd.payload.dot.tag = next_tag;
        r.cmd.payload.dot.chain = chain;
        r.a = a;
        r.b = b;
        next_tag = next_tag + 1'b1;
        send(r);
    endtask

    // Wait for every expected result and every credit to come back
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || owed != 0) && waited < DRAIN_LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        if (exp_q.size() != 0 || owed != 0) begin
            $display("%0d results still missing after %0d cycles", exp_q.size(), waited);
            other_errs++;
        end
        wait_cycles(2);
    endtask

    task automatic unsigned_dots();
        send_cfg(1'b0);
        send_dot(1'b0, fill(8'hFF), fill(8'hFF));
        send_dot(1'b0, 64'h0102_0304_0506_0708, 64'h8070_6050_4030_2010);
        send_dot(1'b0, 64'hFF00_FF00_1234_5678, 64'h0F0F_F0F0_8899_AABB);
        send_dot(1'b0, fill(8'h80), fill(8'h7F));
        wait_drain();
    endtask

    task automatic signed_dots();
        send_cfg(1'b1);
        send_dot(1'b0, fill(8'h80), fill(8'h80));
        send_dot(1'b0, fill(8'h80), fill(8'h7F));
        send_dot(1'b0, 64'hFF01_FE02_FD03_FC04, 64'h0102_0304_8081_F0F1);
        send_dot(1'b0, fill(8'hFF), 64'h0000_0000_0000_0001);
        wait_drain();
    endtask

    // Signed mode still active from the previous test
    task automatic chained_sums();
        send_dot(1'b0, fill(8'hFF), fill(8'h01));
        send_dot(1'b1, fill(8'h80), fill(8'h80));
        send_dot(1'b1, fill(8'h80), fill(8'h80));
        send_dot(1'b0, fill(8'h02), fill(8'h03));
        send_dot(1'b1, fill(8'hF0), fill(8'h10));
        wait_drain();
    endtask

    // Same operands read differently by each mode
    task automatic mode_switching();
        send_cfg(1'b0);
        send_dot(1'b0, 64'hF0E0_D0C0_8090_A0B0, 64'h7F10_FF20_0180_9911);
        send_cfg(1'b1);
        send_dot(1'b0, 64'hF0E0_D0C0_8090_A0B0, 64'h7F10_FF20_0180_9911);
        send_cfg(1'b0);
        send_dot(1'b1, fill(8'hC3), fill(8'h9A));
        send_cfg(1'b1);
        send_dot(1'b1, fill(8'hC3), fill(8'h9A));
        wait_drain();
    endtask

    task automatic output_backpressure();
        int pulses0;
        int recv0;
        int pulses_full;
        pulses0 = in_pulses;
        recv0 = received;
        cred_policy = CRED_HOLD;
        for (int i = 0; i < N_BP; i++) begin
            send_dot(1'b0, fill(ELEM_W'(i * 17 + 3)), fill(ELEM_W'(i * 29 + 5)));
        end
        wait_cycles(20);
        check_count("out_valid count while held", received - recv0, OUT_CREDITS);
        check_count("in_credit count while held", in_pulses - pulses0, RES_DEPTH + OUT_CREDITS);
        // Buffers full, credits must stay quiet
        pulses_full = in_pulses;
        wait_cycles(10);
        check_count("in_credit count once full", in_pulses, pulses_full);
        cred_policy = CRED_NOW;
        wait_drain();
        check_count("in_credit total in back-pressure", in_pulses - pulses0, N_BP);
    endtask

    task automatic random_stream();
        logic      bit_val;
        dotp_vec_t a;
        dotp_vec_t b;
        cred_policy = CRED_RAND;
        for (int i = 0; i < N_RAND; i++) begin
            bit_val = lfsr_step(stim_lfsr);
            a = rand_bits(64);
            b = rand_bits(64);
            // About one command in eight is a mode change
            if (rand_bits(3) == 0) begin
                send_cfg(bit_val);
            end else begin
                send_dot(bit_val, a, b);
            end
        end
        wait_drain();
        cred_policy = CRED_NOW;
    endtask

    // Outputs settle after the rising edge, sampled on the falling one
    always @(negedge clk_i) begin
        if (in_credit) begin
            in_cred++;
            in_pulses++;
        end
        if (out_valid) begin
            owed++;
            received++;
            if (exp_q.size() == 0) begin
                $display("Result with tag %0h arrived with no dot waiting for it", out_res.tag);
                other_errs++;
            end else begin
                check_res(out_res, exp_q.pop_front());
            end
        end
    end

    // Consumer side, one credit per cycle at most
    initial begin
        forever begin
            wait_cycles(1);
            out_credit = 1'b0;
            if (owed > 0 && !reset) begin
                if (cred_policy == CRED_NOW ||
                    (cred_policy == CRED_RAND && lfsr_step(cred_lfsr))) begin
                    out_credit = 1'b1;
                    owed--;
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (200 * NUM_CMDS + RESET_CYCLES));
        $display("Timeout: the run did not finish within the expected time");
        $display("Errors found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        out_credit = 1'b0;
        in_cred = CMD_DEPTH;
        owed = 0;
        cred_policy = CRED_NOW;
        in_pulses = 0;
        received = 0;
        sent_total = 0;
        val_errs = 0;
        other_errs = 0;
        model_signed = 1'b0;
        model_acc = '0;
        next_tag = '0;
        stim_lfsr = 32'h4214_3657;
        cred_lfsr = 32'h4214_3657;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #0.5;
        reset = 1'b0;
        unsigned_dots();
        signed_dots();
        chained_sums();
        mode_switching();
        output_backpressure();
        random_stream();
        // One input credit back per command sent
        check_count("in_credit total", in_pulses, sent_total);
        check_count("results outstanding", exp_q.size(), 0);
        $display("Error counts: %0d value, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verilog/adder_tree.sv
`timescale 1ns/10ps

module adder_tree #(
    parameter int NUM_INPUTS = 8,
    parameter int DATAW = 16
) (
    input  logic [DATAW-1:0]                     data [NUM_INPUTS],
    input  logic                                 sign_unsign_n,
    output logic [DATAW+$clog2(NUM_INPUTS)-1:0]  sum
);

    // NUM_INPUTS is a power of two
    localparam int NUM_LAYERS = $clog2(NUM_INPUTS);

    if (NUM_INPUTS == 1) begin : gen_single
        // Nothing to reduce
        assign sum = data[0];
    end else begin : gen_tree
        for (genvar l = 0; l < NUM_LAYERS; l++) begin : gen_layer
            // Inputs halve and width grows by one per layer
            localparam int LAYER_IN = NUM_INPUTS >> l;
            localparam int LAYER_W = DATAW + l;

            logic [LAYER_W-1:0] layer_in [LAYER_IN];
            logic [LAYER_W:0]   layer_out [LAYER_IN/2];

            if (l == 0) begin : gen_first
                assign layer_in = data;
            end else begin : gen_next
                // Previous layer output
                assign layer_in = gen_layer[l-1].layer_out;
            end

            adder_tree_layer #(
                .NUM_INPUTS(LAYER_IN),
                .DATAW     (LAYER_W)
            ) i_adder_tree_layer (
                .data         (layer_in),
                .sign_unsign_n(sign_unsign_n),
                .sum          (layer_out)
            );
        end

        // Last layer leaves a single word
        assign sum = gen_layer[NUM_LAYERS-1].layer_out[0];
    end

endmodule

// File: verilog/adder_tree_layer.sv
`timescale 1ns/10ps

module adder_tree_layer #(
    parameter int NUM_INPUTS = 2,
    parameter int DATAW = 8
) (
    input  logic [DATAW-1:0] data [NUM_INPUTS],
    input  logic             sign_unsign_n,
    output logic [DATAW:0]   sum [NUM_INPUTS/2]
);

    // One adder per neighbor pair
    for (genvar i = 0; i < NUM_INPUTS / 2; i++) begin : gen_pair
        logic [DATAW:0] lo_ext;
        logic [DATAW:0] hi_ext;

        // Top bit copied in signed mode, zero otherwise
        assign lo_ext = {sign_unsign_n & data[2*i][DATAW-1], data[2*i]};
        assign hi_ext = {sign_unsign_n & data[2*i+1][DATAW-1], data[2*i+1]};

        // Extra bit means no overflow
        assign sum[i] = lo_ext + hi_ext;
    end

endmodule

// File: verilog/dotp_decode.sv
`timescale 1ns/10ps

module dotp_decode (
    input  logic                  clk_i,
    input  logic                  reset,
    input  logic                  req_valid,
    input  dotp_pkg::dotp_req_t   req,
    output logic                  in_credit,
    input  logic                  res_space,
    output logic                  issue_valid,
    output dotp_pkg::dotp_issue_t issue
);
    import dotp_pkg::*;

    // Circular command buffer
    dotp_req_t            cmd_mem [CMD_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_PTR_W:0]   count;

    dotp_req_t head;
    logic      head_valid;
    logic      head_is_dot;
    logic      head_is_cfg;
    logic      push;
    logic      pop;
    // Current signed mode
    logic      mode_signed;

    assign head = cmd_mem[rd_ptr];
    assign head_valid = (count != '0);
    assign head_is_dot = (head.cmd.op == OP_DOT);
    assign head_is_cfg = (head.cmd.op == OP_CONFIG);

    // Dots need a result slot, anything else drains at once
    assign pop = head_valid && (!head_is_dot || res_space);
    // Upstream only sends with a credit, full check is a guard
    assign push = req_valid && ((count != (CMD_PTR_W + 1)'(CMD_DEPTH)) || pop);

    // One credit back per consumed command
    assign in_credit = pop;
    assign issue_valid = pop && head_is_dot;

    // Issue record straight from the head
    always_comb begin
        issue.a = head.a;
        issue.b = head.b;
        issue.tag = head.cmd.payload.dot.tag;
        issue.chain = head.cmd.payload.dot.chain;
        issue.is_signed = mode_signed;
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            cmd_mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            mode_signed <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Mode change seen by the next popped dot
            if (pop && head_is_cfg) begin
                mode_signed <= head.cmd.payload.cfg.is_signed;
            end
        end
    end

endmodule

// File: verilog/dotp_execute.sv
`timescale 1ns/10ps

module dotp_execute (
    input  logic                  clk_i,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  dotp_pkg::dotp_issue_t issue,
    output logic                  exe_valid,
    output dotp_pkg::dotp_res_t   exe_res
);
    import dotp_pkg::*;

    // Stage one, lane products
    logic [NUM_LANES-1:0][PROD_W-1:0] prod_d;
    logic [NUM_LANES-1:0][PROD_W-1:0] prod_q;
    logic                             s1_valid;
    logic [TAG_W-1:0]                 s1_tag;
    logic                             s1_chain;
    logic                             s1_signed;

    // Stage two, tree sum
    logic [PROD_W-1:0] tree_in [NUM_LANES];
    logic [SUM_W-1:0]  tree_sum;
    logic [SUM_W-1:0]  sum_q;
    logic              s2_valid;
    logic [TAG_W-1:0]  s2_tag;
    logic              s2_chain;
    logic              s2_signed;

    // Stage three, accumulator
    logic [ACC_W-1:0] sum_ext;
    logic [ACC_W-1:0] acc_q;
    logic [TAG_W-1:0] s3_tag;

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        logic [PROD_W-1:0] a_ext;
        logic [PROD_W-1:0] b_ext;

        // Extend to product width, low half of the product is exact
        assign a_ext = {{(PROD_W - ELEM_W){issue.is_signed & issue.a[i][ELEM_W-1]}},
                        issue.a[i]};
        assign b_ext = {{(PROD_W - ELEM_W){issue.is_signed & issue.b[i][ELEM_W-1]}},
                        issue.b[i]};
        assign prod_d[i] = a_ext * b_ext;
        assign tree_in[i] = prod_q[i];
    end

    // Combinational reduction of the registered products
    adder_tree #(
        .NUM_INPUTS(NUM_LANES),
        .DATAW     (PROD_W)
    ) i_adder_tree (
        .data         (tree_in),
        .sign_unsign_n(s1_signed),
        .sum          (tree_sum)
    );

    // Widen the tree sum by mode
    assign sum_ext = {{(ACC_W - SUM_W){s2_signed & sum_q[SUM_W-1]}}, sum_q};

    assign exe_res.tag = s3_tag;
    assign exe_res.sum = acc_q;

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (issue_valid) begin
            prod_q <= prod_d;
            s1_tag <= issue.tag;
            s1_chain <= issue.chain;
            s1_signed <= issue.is_signed;
        end
        if (s1_valid) begin
            sum_q <= tree_sum;
            s2_tag <= s1_tag;
            s2_chain <= s1_chain;
            s2_signed <= s1_signed;
        end
        if (s2_valid) begin
            s3_tag <= s2_tag;
        end
    end

    // Valid chain and running sum
    always_ff @(posedge clk_i) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            exe_valid <= 1'b0;
            acc_q <= '0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
            exe_valid <= s2_valid;
            if (s2_valid) begin
                // Wraps at ACC_W
                acc_q <= s2_chain ? acc_q + sum_ext : sum_ext;
            end
        end
    end

endmodule

// File: verilog/dotp_pkg.sv
package dotp_pkg;

    // Datapath sizes
    localparam int NUM_LANES = 8;
    localparam int ELEM_W = 8;
    localparam int PROD_W = 16;
    // Three tree layers on top of the product width
    localparam int SUM_W = 19;
    localparam int ACC_W = 24;
    localparam int TAG_W = 4;

    // Buffering and credits
    localparam int CMD_DEPTH = 4;
    localparam int RES_DEPTH = 4;
    localparam int OUT_CREDITS = 2;

    // Derived pointer and counter widths
    localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
    localparam int RES_PTR_W = $clog2(RES_DEPTH);
    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    typedef enum logic [1:0] {
        OP_CONFIG = 2'd0,
        OP_DOT    = 2'd1
    } dotp_op_e;

    // Configuration view of the payload
    typedef struct packed {
        logic       is_signed;
        logic [5:0] rsvd;
    } dotp_cfg_t;

    // Dot view of the payload
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        // Add to the running sum instead of restarting it
        logic             chain;
        logic [1:0]       rsvd;
    } dotp_dot_t;

    // Same seven bits, read according to the opcode
    typedef union packed {
        dotp_cfg_t cfg;
        dotp_dot_t dot;
    } dotp_payload_u;

    typedef struct packed {
        dotp_op_e      op;
        dotp_payload_u payload;
    } dotp_cmd_t;

    typedef logic [NUM_LANES-1:0][ELEM_W-1:0] dotp_vec_t;

    typedef struct packed {
        dotp_cmd_t cmd;
        dotp_vec_t a;
        dotp_vec_t b;
    } dotp_req_t;

    // Issue record, mode frozen at pop time
    typedef struct packed {
        dotp_vec_t        a;
        dotp_vec_t        b;
        logic [TAG_W-1:0] tag;
        logic             chain;
        logic             is_signed;
    } dotp_issue_t;

    typedef struct packed {
        logic [TAG_W-1:0]        tag;
        logic signed [ACC_W-1:0] sum;
    } dotp_res_t;

endpackage

// File: verilog/dotp_result.sv
`timescale 1ns/10ps

module dotp_result (
    input  logic                clk_i,
    input  logic                reset,
    input  logic                exe_valid,
    input  dotp_pkg::dotp_res_t exe_res,
    input  logic                issue_valid,
    output logic                res_space,
    output logic                out_valid,
    output dotp_pkg::dotp_res_t out_res,
    input  logic                out_credit
);
    import dotp_pkg::*;

    // Result queue
    dotp_res_t            res_mem [RES_DEPTH];
    logic [RES_PTR_W-1:0] wr_ptr;
    logic [RES_PTR_W-1:0] rd_ptr;
    logic [RES_PTR_W:0]   count;

    // Dots issued but not yet out of execute
    logic [RES_PTR_W:0]   inflight;
    logic [RES_PTR_W+1:0] occupied;

    // Output credits held
    logic [CRED_W-1:0] credits;

    logic q_empty;
    logic push;
    logic pop;
    logic bypass;

    assign q_empty = (count == '0);

    // Head visible in the cycle it arrives
    assign out_valid = (!q_empty || exe_valid) && (credits != '0);
    assign out_res = q_empty ? exe_res : res_mem[rd_ptr];

    // Empty queue and a credit, result skips storage
    assign bypass = out_valid && q_empty;
    assign push = exe_valid && !bypass;
    assign pop = out_valid && !q_empty;

    // Every issued dot reserves a slot
    assign occupied = {1'b0, count} + {1'b0, inflight};
    assign res_space = (occupied < (RES_PTR_W + 2)'(RES_DEPTH));

    always_ff @(posedge clk_i) begin
        if (push) begin
            res_mem[wr_ptr] <= exe_res;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            inflight <= '0;
            credits <= CRED_W'(OUT_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({issue_valid, exe_valid})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
            // Spend on send, restore on consumer return
            case ({out_credit, out_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: verilog/dotp_unit.sv
`timescale 1ns/10ps

module dotp_unit (
    input  logic                clk_i,
    input  logic                reset,
    input  logic                req_valid,
    input  dotp_pkg::dotp_req_t req,
    output logic                in_credit,
    output logic                out_valid,
    output dotp_pkg::dotp_res_t out_res,
    input  logic                out_credit
);
    import dotp_pkg::*;

    // Decode to execute
    logic        issue_valid;
    dotp_issue_t issue;

    // Execute to result
    logic      exe_valid;
    dotp_res_t exe_res;

    // Result back to decode
    logic res_space;

    dotp_decode i_dotp_decode (
        .clk_i      (clk_i),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .in_credit  (in_credit),
        .res_space  (res_space),
        .issue_valid(issue_valid),
        .issue      (issue)
    );

    // Fixed three cycle latency, never stalls
    dotp_execute i_dotp_execute (
        .clk_i      (clk_i),
        .reset      (reset),
        .issue_valid(issue_valid),
        .issue      (issue),
        .exe_valid  (exe_valid),
        .exe_res    (exe_res)
    );

    dotp_result i_dotp_result (
        .clk_i      (clk_i),
        .reset      (reset),
        .exe_valid  (exe_valid),
        .exe_res    (exe_res),
        .issue_valid(issue_valid),
        .res_space  (res_space),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

endmodule

// File: vlog.f
verilog/dotp_pkg.sv
verilog/adder_tree_layer.sv
verilog/adder_tree.sv
verilog/dotp_decode.sv
verilog/dotp_execute.sv
verilog/dotp_result.sv
verilog/dotp_unit.sv
verification/dotp_unit_tb.sv
